// ==== Makefile ====
# Verilator build and run for the acquisition testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = bpmAcquisitionTb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: testbench passed"; \
	else \
		echo "Result: testbench failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== acquisition/acquisitionBuffer.sv ====
`timescale 1ns/100ps

`include "bpmAcq_defines.svh"

module acquisitionBuffer (
    input  logic                  sysClk,
    input  logic                  reset,
    input  bpmAcqPkg::acqSampleT  sample,
    input  bpmAcqPkg::triggerBusT triggerStrobes,
    input  logic                  armStrobe,
    input  bpmAcqPkg::triggerBusT triggerMask,
    input  bpmAcqPkg::acqAddrT    ramAddress,
    output bpmAcqPkg::acqWordT    ramData,
    output bpmAcqPkg::acqStatusT  status
);
    import bpmAcqPkg::*;

    // Terminal counts for the pre and post trigger phases
    localparam acqAddrT lastPretrigger  = acqAddrT'(`ACQ_PRETRIGGER - 1);
    localparam acqAddrT lastPosttrigger = acqAddrT'(`ACQ_CAPACITY - `ACQ_PRETRIGGER - 1);

    acqWordT    ram [`ACQ_CAPACITY];
    acqStateT   state;
    acqAddrT    writePointer;
    acqAddrT    sampleCount;
    triggerBusT activeMask;
    triggerBusT maskedStrobes;
    logic       capturing;
    logic       writeEnable;

    always_comb begin
        maskedStrobes = triggerStrobes & activeMask;
        capturing     = (state == acqFilling) ||
                        (state == acqWaiting) ||
                        (state == acqPosttrigger);
        // Arming restarts at address zero, so drop a coincident sample
        writeEnable   = capturing && sample.valid && !armStrobe;
    end

    //////////////////////////////////////////////////
    // Circular memory, one cycle read latency
    always_ff @(posedge sysClk) begin
        if (writeEnable) begin
            ram[writePointer] <= sample.data;
        end
        ramData <= ram[ramAddress];
    end

    //////////////////////////////////////////////////
    // Capture state machine
    always_ff @(posedge sysClk) begin
        if (reset) begin
            state        <= acqIdle;
            writePointer <= '0;
            sampleCount  <= '0;
            activeMask   <= '0;
            status       <= '0;
        end else if (armStrobe) begin
            state        <= acqFilling;
            writePointer <= '0;
            sampleCount  <= '0;
            activeMask   <= triggerMask;
            status.done  <= 1'b0;
            status.armed <= 1'b1;
        end else begin
            // Pointer wraps naturally at memory end
            if (writeEnable) begin
                writePointer <= writePointer + 1'b1;
            end
            case (state)
                acqFilling: begin
                    // Triggers ignored until the pretrigger region is full
                    if (sample.valid) begin
                        sampleCount <= sampleCount + 1'b1;
                        if (sampleCount == lastPretrigger) begin
                            state <= acqWaiting;
                        end
                    end
                end
                acqWaiting: begin
                    if (maskedStrobes != '0) begin
                        state                  <= acqPosttrigger;
                        status.triggerLocation <= writePointer;
                        status.triggerSource   <= maskedStrobes;
                        // A sample in this cycle is the first post-trigger word
                        sampleCount            <= sample.valid ? acqAddrT'(1) : '0;
                    end
                end
                acqPosttrigger: begin
                    if (sample.valid) begin
                        sampleCount <= sampleCount + 1'b1;
                        if (sampleCount == lastPosttrigger) begin
                            state        <= acqDone;
                            status.done  <= 1'b1;
                            status.armed <= 1'b0;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== acquisition/acquisitionReadout.sv ====
`timescale 1ns/100ps

`include "bpmAcq_defines.svh"

module acquisitionReadout (
    input  logic                 sysClk,
    input  logic                 reset,
    input  logic                 readStrobe,
    input  bpmAcqPkg::acqAddrT   readOffset,
    input  bpmAcqPkg::acqStatusT status,
    output bpmAcqPkg::acqAddrT   ramAddress,
    input  bpmAcqPkg::acqWordT   ramData,
    output logic                 readValid,
    output bpmAcqPkg::acqWordT   readData
);
    import bpmAcqPkg::*;

    localparam acqAddrT pretriggerDepth = acqAddrT'(`ACQ_PRETRIGGER);

    acqAddrT targetAddress;
    logic    readPending;

    //////////////////////////////////////////////////
    // Address translation

    // Offset zero is the oldest pretrigger word, modulo memory size
    always_comb begin
        targetAddress = status.triggerLocation - pretriggerDepth + readOffset;
    end

    always_ff @(posedge sysClk) begin
        if (readStrobe) begin
            ramAddress <= targetAddress;
        end
    end

    //////////////////////////////////////////////////
    // Valid pipeline

    // Address register then memory register, one stage each
    always_ff @(posedge sysClk) begin
        if (reset) begin
            readPending <= 1'b0;
            readValid   <= 1'b0;
        end else begin
            readPending <= readStrobe;
            readValid   <= readPending;
        end
    end

    // Memory output register holds the word while readValid is high
    assign readData = ramData;

endmodule

// ==== common/bpmAcqPkg.sv ====
`include "bpmAcq_defines.svh"

package bpmAcqPkg;

    //////////////////////////////////////////////////
    // Vector types

    // Magnitude from preliminary processing
    typedef logic signed [`MAG_WIDTH-1:0]      magT;

    // Word as stored in acquisition memory
    typedef logic [`ACQ_WIDTH-1:0]             acqWordT;

    typedef logic [`EVR_TRIGGER_WIDTH-1:0]     evrTriggerBusT;

    // Bit 0 software trigger, bits 1..6 event lines 2..7
    typedef logic [`ACQ_TRIGGER_WIDTH-1:0]     triggerBusT;

    // Memory address, also used for read offsets
    typedef logic [`ACQ_ADDR_WIDTH-1:0]        acqAddrT;

    //////////////////////////////////////////////////
    // Structs

    typedef struct packed {
        logic    valid;
        acqWordT data;
    } acqSampleT;

    typedef struct packed {
        logic       done;
        logic       armed;
        acqAddrT    triggerLocation;
        triggerBusT triggerSource;
    } acqStatusT;

    //////////////////////////////////////////////////
    // Buffer state machine
    typedef enum logic [2:0] {
        acqIdle,
        acqFilling,
        acqWaiting,
        acqPosttrigger,
        acqDone
    } acqStateT;

endpackage

// ==== common/bpmAcq_defines.svh ====
`ifndef BPM_ACQ_DEFINES_SVH
`define BPM_ACQ_DEFINES_SVH

// Sample widths
`define MAG_WIDTH          26
`define ACQ_WIDTH          32

// Trigger bus widths
// Event bus carries heartbeat and PPS on bits 0 and 1
`define EVR_TRIGGER_WIDTH  8
`define ACQ_TRIGGER_WIDTH  7

// Acquisition memory geometry
`define ACQ_CAPACITY       64
`define ACQ_ADDR_WIDTH     6

// Words held ahead of the trigger
`define ACQ_PRETRIGGER     16

`endif

// ==== hdl/bpmAcquisitionTop.sv ====
`timescale 1ns/100ps

module bpmAcquisitionTop (
    input  logic                     sysClk,
    input  logic                     reset,
    input  logic                     magValid,
    input  bpmAcqPkg::magT           magnitude,
    input  bpmAcqPkg::evrTriggerBusT evrTriggers,
    input  logic                     softTrigger,
    input  logic                     armStrobe,
    input  bpmAcqPkg::triggerBusT    triggerMask,
    input  logic                     readStrobe,
    input  bpmAcqPkg::acqAddrT       readOffset,
    output bpmAcqPkg::acqStatusT     status,
    output logic                     readValid,
    output bpmAcqPkg::acqWordT       readData
);
    import bpmAcqPkg::*;

    acqSampleT  sample;
    triggerBusT triggerStrobes;
    acqAddrT    ramAddress;
    acqWordT    ramData;

    //////////////////////////////////////////////////
    // Sample and trigger conditioning
    triggerConditioner i_triggerConditioner (
        .sysClk         (sysClk),
        .reset          (reset),
        .magValid       (magValid),
        .magnitude      (magnitude),
        .evrTriggers    (evrTriggers),
        .softTrigger    (softTrigger),
        .sample         (sample),
        .triggerStrobes (triggerStrobes)
    );

    //////////////////////////////////////////////////
    // Acquisition memory
    acquisitionBuffer i_acquisitionBuffer (
        .sysClk         (sysClk),
        .reset          (reset),
        .sample         (sample),
        .triggerStrobes (triggerStrobes),
        .armStrobe      (armStrobe),
        .triggerMask    (triggerMask),
        .ramAddress     (ramAddress),
        .ramData        (ramData),
        .status         (status)
    );

    //////////////////////////////////////////////////
    // Readout
    acquisitionReadout i_acquisitionReadout (
        .sysClk     (sysClk),
        .reset      (reset),
        .readStrobe (readStrobe),
        .readOffset (readOffset),
        .status     (status),
        .ramAddress (ramAddress),
        .ramData    (ramData),
        .readValid  (readValid),
        .readData   (readData)
    );

endmodule

// ==== hdl/triggerConditioner.sv ====
`timescale 1ns/100ps

`include "bpmAcq_defines.svh"

module triggerConditioner (
    input  logic                     sysClk,
    input  logic                     reset,
    input  logic                     magValid,
    input  bpmAcqPkg::magT           magnitude,
    input  bpmAcqPkg::evrTriggerBusT evrTriggers,
    input  logic                     softTrigger,
    output bpmAcqPkg::acqSampleT     sample,
    output bpmAcqPkg::triggerBusT    triggerStrobes
);
    import bpmAcqPkg::*;

    localparam int extendBits = `ACQ_WIDTH - `MAG_WIDTH;

    acqWordT                       widened;
    logic [`ACQ_TRIGGER_WIDTH-2:0] eventMeta;
    logic [`ACQ_TRIGGER_WIDTH-2:0] eventSync;
    logic [`ACQ_TRIGGER_WIDTH-2:0] eventDelayed;

    //////////////////////////////////////////////////
    // Sample path

    // Sign extend to full acquisition word
    always_comb begin
        widened = {{extendBits{magnitude[`MAG_WIDTH-1]}}, magnitude};
    end

    always_ff @(posedge sysClk) begin
        sample.data <= widened;
        if (reset) begin
            sample.valid <= 1'b0;
        end else begin
            sample.valid <= magValid;
        end
    end

    //////////////////////////////////////////////////
    // Trigger path

    // Event lines 2..7 are asynchronous, two flops then edge detect.
    // Heartbeat and PPS lines are not acquisition triggers.
    always_ff @(posedge sysClk) begin
        if (reset) begin
            eventMeta      <= '0;
            eventSync      <= '0;
            eventDelayed   <= '0;
            triggerStrobes <= '0;
        end else begin
            eventMeta    <= evrTriggers[`EVR_TRIGGER_WIDTH-1:2];
            eventSync    <= eventMeta;
            eventDelayed <= eventSync;
            // Software strobe is already synchronous
            triggerStrobes <= {eventSync & ~eventDelayed, softTrigger};
        end
    end

endmodule

// ==== sources.f ====
+incdir+common
common/bpmAcqPkg.sv
hdl/triggerConditioner.sv
acquisition/acquisitionBuffer.sv
acquisition/acquisitionReadout.sv
hdl/bpmAcquisitionTop.sv
verification/bpmAcquisitionTb.sv

// ==== verification/bpmAcquisitionTb.sv ====
`timescale 1ns/100ps

`include "bpmAcq_defines.svh"

module bpmAcquisitionTb;
    import bpmAcqPkg::*;

    // Each test takes a few hundred cycles, five tests plus margin
    localparam int timeoutCycles = 3000;
    localparam triggerBusT softBit  = 7'b0000001;
    localparam triggerBusT line4Bit = 7'b0001000;

    logic          sysClk = 1'b0;
    logic          reset;
    logic          magValid;
    magT           magnitude;
    evrTriggerBusT evrTriggers;
    logic          softTrigger;
    logic          armStrobe;
    triggerBusT    triggerMask;
    logic          readStrobe;
    acqAddrT       readOffset;
    acqStatusT     status;
    logic          readValid;
    acqWordT       readData;

    // Samples driven since the last arm, and index of first post-trigger sample
    magT     samples[$];
    int      triggerIndex;
    int      seed = 32'h5fb3;
    int      cycleCount;
    int      errorCount;
    int      checkCount;
    int      testsRun;
    int      testsFailed;
    int      testStartErrors;
    logic    strobeHistory [2];
    acqAddrT offsetHistory [2];

    bpmAcquisitionTop i_bpmAcquisitionTop (
        .sysClk      (sysClk),
        .reset       (reset),
        .magValid    (magValid),
        .magnitude   (magnitude),
        .evrTriggers (evrTriggers),
        .softTrigger (softTrigger),
        .armStrobe   (armStrobe),
        .triggerMask (triggerMask),
        .readStrobe  (readStrobe),
        .readOffset  (readOffset),
        .status      (status),
        .readValid   (readValid),
        .readData    (readData)
    );

    always #50 sysClk = ~sysClk;

    //////////////////////////////////////////////////
    // Reference model and compare tasks

    // Offset zero is the 16th sample before the trigger
    function automatic acqWordT expectedWord(input acqAddrT offset);
        int  index;
        magT value;
        index = triggerIndex - `ACQ_PRETRIGGER + int'(offset);
        value = samples[index];
        return {{(`ACQ_WIDTH - `MAG_WIDTH){value[`MAG_WIDTH-1]}}, value};
    endfunction

    task automatic checkWord(input string name, input acqWordT actual, input acqWordT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
        end
    endtask

    task automatic checkStatus(input string name, input acqStatusT actual,
                               input acqStatusT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Read response must follow each strobe by exactly two cycles
    always @(negedge sysClk) begin
        checkFlag("readValid", readValid, strobeHistory[1]);
        if (strobeHistory[1]) begin
            checkWord("readData", readData, expectedWord(offsetHistory[1]));
        end
        strobeHistory[1] = strobeHistory[0];
        offsetHistory[1] = offsetHistory[0];
        strobeHistory[0] = readStrobe;
        offsetHistory[0] = readOffset;
    end

    always @(posedge sysClk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run did not complete within %0d cycles", timeoutCycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus tasks

    task automatic armCapture(input triggerBusT mask);
        @(posedge sysClk);
        armStrobe   <= 1'b1;
        triggerMask <= mask;
        @(posedge sysClk);
        armStrobe <= 1'b0;
        samples.delete();
        @(posedge sysClk);
    endtask

    task automatic driveSamples(input int count);
        int value;
        repeat (count) begin
            @(posedge sysClk);
            value = $random(seed);
            magValid  <= 1'b1;
            magnitude <= value[`MAG_WIDTH-1:0];
            samples.push_back(value[`MAG_WIDTH-1:0]);
        end
        @(posedge sysClk);
        magValid <= 1'b0;
    endtask

    // Quiet stream around the trigger so its sample index is unambiguous
    task automatic pulseSoftTrigger();
        repeat (3) @(posedge sysClk);
        triggerIndex = samples.size();
        @(posedge sysClk);
        softTrigger <= 1'b1;
        @(posedge sysClk);
        softTrigger <= 1'b0;
        repeat (5) @(posedge sysClk);
    endtask

    task automatic raiseEventLine(input int line);
        repeat (3) @(posedge sysClk);
        triggerIndex = samples.size();
        @(posedge sysClk);
        evrTriggers[line] <= 1'b1;
        repeat (6) @(posedge sysClk);
    endtask

    task automatic issueReads(input int first, input int count, input int gap);
        int i;
        for (i = 0; i < count; i++) begin
            @(posedge sysClk);
            readStrobe <= 1'b1;
            readOffset <= acqAddrT'(first + i);
            if (gap > 0) begin
                @(posedge sysClk);
                readStrobe <= 1'b0;
                repeat (gap - 1) @(posedge sysClk);
            end
        end
        @(posedge sysClk);
        readStrobe <= 1'b0;
        repeat (3) @(posedge sysClk);
    endtask

    task automatic waitForDone();
        int waited;
        waited = 0;
        @(negedge sysClk);
        while (status.done !== 1'b1 && waited < 100) begin
            @(negedge sysClk);
            waited++;
        end
        if (status.done !== 1'b1) begin
            errorCount++;
            $display("Capture did not complete at %0t, done never rose", $time);
        end
    endtask

    // Status after a capture, then the whole buffer from the oldest word
    task automatic checkCapture(input triggerBusT source);
        acqStatusT expected;
        expected.done            = 1'b1;
        expected.armed           = 1'b0;
        expected.triggerLocation = acqAddrT'(triggerIndex % `ACQ_CAPACITY);
        expected.triggerSource   = source;
        waitForDone();
        checkStatus("status", status, expected);
        issueReads(0, `ACQ_CAPACITY, 0);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount == testStartErrors) begin
            $display("Test %0d %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", testsRun, name,
                     errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        reset       = 1'b1;
        magValid    = 1'b0;
        magnitude   = '0;
        evrTriggers = '0;
        softTrigger = 1'b0;
        armStrobe   = 1'b0;
        triggerMask = '0;
        readStrobe  = 1'b0;
        readOffset  = '0;
        strobeHistory = '{1'b0, 1'b0};
        offsetHistory = '{'0, '0};
        repeat (10) @(posedge sysClk);
        reset <= 1'b0;

        armCapture(softBit);
        driveSamples(30);
        pulseSoftTrigger();
        driveSamples(60);
        checkCapture(softBit);
        finishTest("software trigger capture");

        armCapture(line4Bit);
        driveSamples(30);
        raiseEventLine(4);
        driveSamples(60);
        checkCapture(line4Bit);
        @(posedge sysClk);
        evrTriggers <= '0;
        finishTest("event trigger capture");

        // Early soft trigger lands in filling, line 5 is masked off
        armCapture(softBit);
        driveSamples(5);
        @(posedge sysClk);
        softTrigger <= 1'b1;
        @(posedge sysClk);
        softTrigger <= 1'b0;
        driveSamples(15);
        @(posedge sysClk);
        evrTriggers[5] <= 1'b1;
        driveSamples(100);
        repeat (4) @(negedge sysClk);
        checkFlag("status.done", status.done, 1'b0);
        checkFlag("status.armed", status.armed, 1'b1);
        pulseSoftTrigger();
        driveSamples(60);
        checkCapture(softBit);
        @(posedge sysClk);
        evrTriggers <= '0;
        finishTest("masking and fill guard");

        // Trigger at 56, so offset 24 crosses the memory end
        issueReads(16, 25, 0);
        issueReads(20, 8, 2);
        finishTest("readout latency and wraparound");

        @(posedge sysClk);
        reset <= 1'b1;
        repeat (10) @(posedge sysClk);
        reset <= 1'b0;
        @(negedge sysClk);
        checkStatus("status", status, '0);
        checkFlag("readValid", readValid, 1'b0);
        armCapture(softBit);
        driveSamples(20);
        pulseSoftTrigger();
        driveSamples(20);
        armCapture(softBit);
        @(negedge sysClk);
        checkFlag("status.armed", status.armed, 1'b1);
        checkFlag("status.done", status.done, 1'b0);
        driveSamples(30);
        pulseSoftTrigger();
        driveSamples(60);
        checkCapture(softBit);
        finishTest("reset and re-arm");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
